// File: common/vtl_cfg.svh
// Laser 500 video controller constants
// raster timing, port numbers, memory map and palette
`ifndef VTL_CFG_SVH
`define VTL_CFG_SVH

// horizontal timing in F14M clocks
`define VTL_HSW         66
`define VTL_HBP         70
`define VTL_HFP         10
`define VTL_H_VISIBLE   798

// vertical timing in lines
`define VTL_V_LINES     313
`define VTL_VSW         2
`define VTL_V_VIS_FIRST 4
`define VTL_V_VIS_LAST  310

// active area
`define VTL_WIDTH       640
`define VTL_HEIGHT      192
`define VTL_LEFT_BORDER 72
`define VTL_TOP_BORDER  65

// fetch runs two bytes ahead of the shifter
`define VTL_FETCH_LEAD  16

// z80 i/o ports
`define VTL_PORT_BANK0     8'h40
`define VTL_PORT_VDC_MODE  8'h44
`define VTL_PORT_VDC_COLOR 8'h45
`define VTL_MODE_GR3       3'b011

// memory map
`define VTL_MAPPED_IO_BANK 4'd2
`define VTL_MAPPED_IO_LO   14'h2800
`define VTL_MAPPED_IO_HI   14'h2FFF
`define VTL_VIDEO_PAGE7    4'h7
`define VTL_VIDEO_PAGE3    4'h3

// palette, 4 bits per component rgb
`define VTL_PAL_0 12'h000
`define VTL_PAL_1 12'h00F
`define VTL_PAL_2 12'h080
`define VTL_PAL_3 12'h08F
`define VTL_PAL_4 12'hA00
`define VTL_PAL_5 12'hF0F
`define VTL_PAL_6 12'h780
`define VTL_PAL_7 12'h999
`define VTL_PAL_8 12'h555
`define VTL_PAL_9 12'h88F
`define VTL_PAL_A 12'h0F0
`define VTL_PAL_B 12'h4FF
`define VTL_PAL_C 12'hF45
`define VTL_PAL_D 12'hF9F
`define VTL_PAL_E 12'hCF0
`define VTL_PAL_F 12'hFFF

`endif

// File: common/vtl_pkg.sv
// Laser 500 video controller types
// raster state, video registers, memory requests, i/o byte decode
`default_nettype none

package vtl_pkg;

	// one clock of raster state from the timing block
	typedef struct packed {
		logic [2:0] slot;        // memory slot, low 3 bits of hcnt
		logic [9:0] active_x;    // hcnt relative to active area start
		logic [9:0] active_y;    // vcnt relative to active area start
		logic       visible;
		logic       border;
		logic       active;
		logic       video_fetch; // slot 7
		logic       refresh;     // slot 3
	} raster_t;

	typedef struct packed {
		logic       gfx_en;  // mapped i/o bit 3
		logic       gr3;     // otherwise gr5
		logic       page7;   // video ram page, 3 when clear
		logic [3:0] border;
		logic [3:0] fg;
		logic [3:0] bg;
	} vdc_regs_t;

	typedef struct packed {
		logic [3:0]  bank;
		logic [13:0] offset;
	} mem_addr_t;

	typedef struct packed {
		logic      valid;
		logic      write;
		mem_addr_t addr;
		logic [7:0] wdata;
	} mem_req_t;

	// port 0x44 byte
	typedef struct packed {
		logic [3:0] border;
		logic       page3;
		logic [2:0] mode;
	} vdc_mode_t;

	// port 0x45 byte
	typedef struct packed {
		logic [3:0] fg;
		logic [3:0] bg;
	} color_pair_t;

	typedef union packed {
		vdc_mode_t   mode;
		color_pair_t colors;
	} io_word_u;

endpackage

`default_nettype wire

// File: cpu/cpu_bus.sv
// Z80 bus side of the controller
// clock enable with skipped beat, bank switching, vdc ports and mapped i/o
`timescale 1ns/100ps
`default_nettype none
`include "vtl_cfg.svh"

module cpu_bus (
	input  logic               F14M,
	input  logic               RESET,
	input  vtl_pkg::raster_t   raster,
	input  logic               mreq_n,
	input  logic               iorq_n,
	input  logic               rd_n,
	input  logic               wr_n,
	input  logic [15:0]        a,
	input  logic [7:0]         cpu_do,
	input  logic [6:0]         kd,
	input  logic               casin,
	input  logic [7:0]         sdram_dout,
	output logic               cpu_ena,
	output logic [7:0]         cpu_di,
	output vtl_pkg::mem_req_t  mem_req,
	output vtl_pkg::vdc_regs_t regs,
	output logic               buzzer,
	output logic               casout
);
	import vtl_pkg::*;

	logic mreq, iorq, rd, wr;
	logic [1:0]  phase;        // 4 clock cpu cycle
	logic        mreq_old;
	logic        skip_beat;
	logic [3:0]  banks [4];    // 16k windows
	logic [3:0]  bank;
	logic [13:0] offset;
	logic        bank_is_ram;
	logic        mapped_io;
	logic        bus_go;       // access allowed this beat
	io_word_u    io_word;

	assign mreq  = !mreq_n;
	assign iorq  = !iorq_n;
	assign rd    = !rd_n;
	assign wr    = !wr_n;
	assign phase = raster.slot[1:0];

	assign bank        = banks[a[15:14]];
	assign offset      = a[13:0];
	assign bank_is_ram = (bank >= 4'd4) && (bank <= 4'd7);
	assign mapped_io   = (bank == `VTL_MAPPED_IO_BANK) &&
	                     (offset >= `VTL_MAPPED_IO_LO) && (offset <= `VTL_MAPPED_IO_HI);
	assign bus_go  = !skip_beat;
	assign io_word = cpu_do;

	// sdram access goes out during phase 1
	always_comb begin
		mem_req.valid       = (phase == 2'd1) && mreq && bus_go && !mapped_io;
		mem_req.write       = wr && bank_is_ram;  // rom writes dropped
		mem_req.addr.bank   = bank;
		mem_req.addr.offset = offset;
		mem_req.wdata       = cpu_do;
	end

	always_ff @(posedge F14M) begin
		if (RESET) begin
			mreq_old     <= 1'b0;
			skip_beat    <= 1'b0;
			cpu_ena      <= 1'b0;
			buzzer       <= 1'b0;
			casout       <= 1'b0;
			for (int i = 0; i < 4; i++)
				banks[i] <= 4'h0;
			regs.gfx_en  <= 1'b0;
			regs.gr3     <= 1'b0;
			regs.page7   <= 1'b1;
			regs.border  <= 4'h0;
			regs.fg      <= 4'hF;
			regs.bg      <= 4'h0;
		end else begin
			// new mreq costs one beat
			if (phase == 2'd3) begin
				mreq_old  <= mreq;
				skip_beat <= mreq && !mreq_old;
			end
			cpu_ena <= (phase == 2'd0) && !skip_beat;  // one clock wide

			if (phase == 2'd1 && mreq && wr && bus_go && mapped_io) begin
				buzzer      <= cpu_do[0];
				casout      <= cpu_do[2];
				regs.gfx_en <= cpu_do[3];
			end

			if (phase == 2'd2 && iorq && wr && bus_go) begin
				if ({a[7:2], 2'b00} == `VTL_PORT_BANK0)
					banks[a[1:0]] <= cpu_do[3:0];   // ports 0x40 to 0x43
				else if (a[7:0] == `VTL_PORT_VDC_MODE) begin
					regs.border <= io_word.mode.border;
					regs.page7  <= !io_word.mode.page3;
					regs.gr3    <= (io_word.mode.mode == `VTL_MODE_GR3);
				end else if (a[7:0] == `VTL_PORT_VDC_COLOR) begin
					regs.fg <= io_word.colors.fg;
					regs.bg <= io_word.colors.bg;
				end
			end
		end
	end

	// cpu samples the bus at phase 2
	always_ff @(posedge F14M) begin
		if (phase == 2'd2 && bus_go && rd) begin
			if (mreq)
				cpu_di <= mapped_io ? {casin, kd} : sdram_dout;
			else if (iorq)
				cpu_di <= 8'hFF;  // no readable ports
		end
	end

endmodule

`default_nettype wire

// File: hw/sdram_slot_arbiter.sv
// SDRAM slot arbiter
// video fetch on slot 7, refresh gap on slot 3, cpu on its phase 1
`timescale 1ns/100ps
`default_nettype none
`include "vtl_cfg.svh"

module sdram_slot_arbiter (
	input  logic              F14M,
	input  logic              RESET,
	input  vtl_pkg::raster_t  raster,
	input  logic [13:0]       video_addr,
	input  logic              page7,
	input  vtl_pkg::mem_req_t mem_req,
	output logic [24:0]       sdram_addr,
	output logic [7:0]        sdram_din,
	output logic              sdram_wr,
	output logic              sdram_rd
);
	logic [17:0] addr_q;       // bank and offset
	logic [3:0]  video_page;

	assign video_page = page7 ? `VTL_VIDEO_PAGE7 : `VTL_VIDEO_PAGE3;
	assign sdram_addr = {7'd0, addr_q};

	always_ff @(posedge F14M) begin
		if (RESET) begin
			sdram_wr <= 1'b0;
			sdram_rd <= 1'b0;
		end else if (raster.video_fetch) begin
			sdram_wr <= 1'b0;
			sdram_rd <= 1'b1;
		end else if (mem_req.valid) begin
			sdram_wr <= mem_req.write;
			sdram_rd <= !mem_req.write;
		end else begin
			sdram_wr <= 1'b0;   // cpu request over
			if (raster.refresh)
				sdram_rd <= 1'b0;
		end
	end

	always_ff @(posedge F14M) begin
		if (raster.video_fetch)
			addr_q <= {video_page, video_addr};
		else if (mem_req.valid) begin
			addr_q    <= mem_req.addr;
			sdram_din <= mem_req.wdata;
		end
	end

endmodule

`default_nettype wire

// File: hw/vtl_chip.sv
// Laser 500 video and bus controller
// raster timing and pixel path beside the z80 bus, sharing one sdram port
`timescale 1ns/100ps
`default_nettype none

module vtl_chip (
	input  logic        F14M,
	input  logic        RESET,
	input  logic        blank,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic [15:0] a,
	input  logic [7:0]  cpu_do,
	input  logic [6:0]  kd,
	input  logic        casin,
	output logic [7:0]  cpu_di,
	output logic        cpu_ena,
	input  logic [7:0]  sdram_dout,
	output logic [24:0] sdram_addr,
	output logic [7:0]  sdram_din,
	output logic        sdram_wr,
	output logic        sdram_rd,
	output logic        hsync,
	output logic        vsync,
	output logic        display_enable,
	output logic [5:0]  r,
	output logic [5:0]  g,
	output logic [5:0]  b,
	output logic        buzzer,
	output logic        casout
);
	import vtl_pkg::*;

	raster_t    raster;
	vdc_regs_t  regs;
	mem_req_t   mem_req;
	logic [13:0] video_addr;

	video_timing u_timing (
		.F14M(F14M), .RESET(RESET),
		.raster(raster), .hsync(hsync), .vsync(vsync), .display_enable(display_enable)
	);

	video_shifter u_shifter (
		.F14M(F14M), .RESET(RESET), .blank(blank),
		.raster(raster), .regs(regs), .sdram_dout(sdram_dout),
		.video_addr(video_addr), .r(r), .g(g), .b(b)
	);

	cpu_bus u_cpu (
		.F14M(F14M), .RESET(RESET), .raster(raster),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .cpu_do(cpu_do), .kd(kd), .casin(casin), .sdram_dout(sdram_dout),
		.cpu_ena(cpu_ena), .cpu_di(cpu_di), .mem_req(mem_req), .regs(regs),
		.buzzer(buzzer), .casout(casout)
	);

	sdram_slot_arbiter u_arb (
		.F14M(F14M), .RESET(RESET), .raster(raster),
		.video_addr(video_addr), .page7(regs.page7), .mem_req(mem_req),
		.sdram_addr(sdram_addr), .sdram_din(sdram_din),
		.sdram_wr(sdram_wr), .sdram_rd(sdram_rd)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the vtl_chip testbench with Verilator and run it
# the exit status of the simulation is the result
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -f vtl_chip.f --top-module tb_vtl_chip \
	-o sim_vtl_chip \
	&& ./obj_dir/sim_vtl_chip \
	|| exit 1

// File: testbench/tb_vtl_chip.sv
// testbench for the Laser 500 video and bus controller
// sdram model, z80 bus tasks and directed tests of sync, memory, i/o and video
`timescale 1ns/100ps
`default_nettype none
`include "vtl_cfg.svh"

module tb_vtl_chip;
	localparam int LINE_CLKS = 944;
	localparam int FRAME_CLKS = 313 * LINE_CLKS;
	localparam int TIMEOUT = 1500000;  // about five frames

	logic        F14M, RESET, blank;
	logic        mreq_n, iorq_n, rd_n, wr_n;
	logic [15:0] a;
	logic [7:0]  cpu_do, cpu_di, sdram_dout, sdram_din;
	logic [6:0]  kd;
	logic        casin, cpu_ena, sdram_wr, sdram_rd;
	logic [24:0] sdram_addr;
	logic        hsync, vsync, display_enable, buzzer, casout;
	logic [5:0]  r, g, b;

	logic [7:0] mem [0:262143];  // 16 banks of 16k
	int         cycles;
	int         color_count [17];  // per palette entry, 16 = no match

	vtl_chip dut (
		.F14M(F14M), .RESET(RESET), .blank(blank),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.a(a), .cpu_do(cpu_do), .kd(kd), .casin(casin),
		.cpu_di(cpu_di), .cpu_ena(cpu_ena), .sdram_dout(sdram_dout),
		.sdram_addr(sdram_addr), .sdram_din(sdram_din),
		.sdram_wr(sdram_wr), .sdram_rd(sdram_rd),
		.hsync(hsync), .vsync(vsync), .display_enable(display_enable),
		.r(r), .g(g), .b(b), .buzzer(buzzer), .casout(casout)
	);

	always #10 F14M = !F14M;

	// async read, write at the edge
	assign sdram_dout = mem[sdram_addr[17:0]];
	always @(posedge F14M) begin
		if (sdram_wr)
			mem[sdram_addr[17:0]] <= sdram_din;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge F14M) begin
		cycles++;
		if (cycles >= TIMEOUT)
			abort_run("timeout, the tests did not finish in time");
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
	                           input string what);
		assert (got == exp)
		else abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %0h expected %0h",
		                         $time, what, got, exp));
	endtask

	// palette entry as seen on the 6 bit outputs
	function automatic logic [17:0] expand(input logic [3:0] idx);
		logic [11:0] p;
		case (idx)
			4'h0: p = `VTL_PAL_0;
			4'h1: p = `VTL_PAL_1;
			4'h2: p = `VTL_PAL_2;
			4'h3: p = `VTL_PAL_3;
			4'h4: p = `VTL_PAL_4;
			4'h5: p = `VTL_PAL_5;
			4'h6: p = `VTL_PAL_6;
			4'h7: p = `VTL_PAL_7;
			4'h8: p = `VTL_PAL_8;
			4'h9: p = `VTL_PAL_9;
			4'hA: p = `VTL_PAL_A;
			4'hB: p = `VTL_PAL_B;
			4'hC: p = `VTL_PAL_C;
			4'hD: p = `VTL_PAL_D;
			4'hE: p = `VTL_PAL_E;
			default: p = `VTL_PAL_F;
		endcase
		expand = {p[11:8], p[11:10], p[7:4], p[7:6], p[3:0], p[3:2]};
	endfunction

	// one z80 access, held until the enable after the skipped beat
	task automatic bus_access(input logic io, input logic write, input logic [15:0] addr,
	                          input logic [7:0] data, output logic [7:0] rdata,
	                          output logic wr_seen, output logic [24:0] wr_addr);
		int pulses;
		int waited;
		pulses  = 0;
		waited  = 0;
		wr_seen = 1'b0;
		wr_addr = '0;
		@(posedge F14M);
		#1;
		a      = addr;
		cpu_do = data;
		mreq_n = io;
		iorq_n = !io;
		rd_n   = write;
		wr_n   = !write;
		while (pulses < 2) begin
			@(negedge F14M);
			if (cpu_ena)
				pulses++;
			if (sdram_wr) begin
				wr_seen = 1'b1;
				wr_addr = sdram_addr;
			end
			waited++;
			if (waited > 64)
				abort_run("bus access got no clock enable from the DUT");
		end
		// phase 1 issue, phase 2 sample
		repeat (2) begin
			@(negedge F14M);
			if (sdram_wr) begin
				wr_seen = 1'b1;
				wr_addr = sdram_addr;
			end
		end
		rdata = cpu_di;
		@(posedge F14M);
		#1;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic io_write(input logic [7:0] port, input logic [7:0] data);
		logic [7:0]  rd;
		logic        ws;
		logic [24:0] wa;
		bus_access(1'b1, 1'b1, {8'h00, port}, data, rd, ws, wa);
	endtask

	task automatic fill_bank(input logic [3:0] bank, input logic [7:0] value);
		for (int i = 0; i < 16384; i++)
			mem[{bank, 14'(i)}] <= value;
	endtask

	// leaves the run at the negedge of hcount 0 of line n
	task automatic wait_for_line(input int n);
		logic prev;
		int   line;
		prev = 1'b1;
		forever begin
			@(negedge F14M);
			if (!prev && vsync)
				break;  // line 2 starts
			prev = vsync;
		end
		line = 2;
		while (line < n) begin
			prev = hsync;
			@(negedge F14M);
			if (prev && !hsync)
				line++;
		end
	endtask

	task automatic count_line_colors();
		int idx;
		for (int k = 0; k < 17; k++)
			color_count[k] = 0;
		for (int i = 0; i < LINE_CLKS; i++) begin
			idx = 16;
			for (int k = 0; k < 16; k++)
				if ({r, g, b} == expand(4'(k)))
					idx = k;
			color_count[idx]++;
			@(negedge F14M);
		end
	endtask

	task automatic sync_timing();
		logic prev_h, prev_v;
		int   n, last_fall, low;
		n = 0;
		last_fall = 0;
		low = 0;
		prev_v = 1'b1;
		forever begin
			@(negedge F14M);
			if (!prev_v && vsync)
				break;
			prev_v = vsync;
		end
		prev_v = vsync;
		forever begin
			prev_h = hsync;
			@(negedge F14M);
			n++;
			if (!vsync)
				low++;
			// idle bus, video read holds sdram_rd from slot 0 to slot 3
			check_value(32'(sdram_rd), 32'((n % 8) < 4), "sdram_rd slot window");
			if (prev_h && !hsync) begin
				check_value(32'(n - last_fall), 32'(LINE_CLKS), "hsync period");
				last_fall = n;
			end
			if (!prev_v && vsync)
				break;
			prev_v = vsync;
		end
		check_value(32'(n), 32'(FRAME_CLKS), "frame length");
		check_value(32'(low), 32'(2 * LINE_CLKS), "vsync low time");
	endtask

	task automatic banked_memory();
		logic [13:0] off;
		logic [7:0]  data, rd;
		logic        ws;
		logic [24:0] wa;
		off  = 14'($urandom);
		do data = 8'($urandom);
		while (data == mem[{4'd5, off}]);  // write has to change the cell
		io_write(8'h41, 8'h05);
		bus_access(1'b0, 1'b1, 16'h4000 | {2'b00, off}, data, rd, ws, wa);
		check_value(32'(ws), 32'd1, "sdram_wr on bank 5 write");
		check_value(32'(wa), 32'({7'd0, 4'd5, off}), "sdram write address");
		bus_access(1'b0, 1'b0, 16'h4000 | {2'b00, off}, 8'h00, rd, ws, wa);
		check_value(32'(rd), 32'(data), "read back through cpu_di");
	endtask

	task automatic mapped_io();
		logic [7:0]  data, rd;
		logic        ws;
		logic [24:0] wa;
		data = (8'($urandom) & 8'hF2) | 8'h05;  // buzzer and casout on, graphics off
		kd    = 7'($urandom);
		casin = 1'($urandom);
		io_write(8'h41, 8'h02);
		bus_access(1'b0, 1'b1, 16'h6800 + 16'($urandom_range(2047, 0)), data, rd, ws, wa);
		check_value(32'(buzzer), 32'(data[0]), "buzzer from bit 0");
		check_value(32'(casout), 32'(data[2]), "casout from bit 2");
		check_value(32'(ws), 32'd0, "no sdram write for mapped i/o");
		bus_access(1'b0, 1'b0, 16'h6FFF, 8'h00, rd, ws, wa);
		check_value(32'(rd), 32'({casin, kd}), "mapped i/o read");
		bus_access(1'b1, 1'b0, 16'h0030, 8'h00, rd, ws, wa);
		check_value(32'(rd), 32'hFF, "unused port read");
	endtask

	task automatic gr5_colors();
		logic [3:0]  fg, bg, border;
		logic [7:0]  rd;
		logic        ws;
		logic [24:0] wa;
		fg = 4'($urandom_range(15, 1));
		do bg = 4'($urandom_range(15, 1)); while (bg == fg);
		do border = 4'($urandom_range(15, 1)); while (border == fg || border == bg);
		fill_bank(4'h7, 8'h0F);
		fill_bank(4'h3, 8'h0F);
		io_write(8'h44, {border, 1'b0, 3'b000});
		io_write(8'h45, {fg, bg});
		bus_access(1'b0, 1'b1, 16'h6800, 8'h08, rd, ws, wa);  // graphics on
		check_value(32'(buzzer), 32'd0, "buzzer cleared");
		check_value(32'(casout), 32'd0, "casout cleared");
		wait_for_line(100);
		count_line_colors();
		check_value(32'(color_count[fg]), 32'd320, "gr5 foreground count");
		check_value(32'(color_count[bg]), 32'd320, "gr5 background count");
		check_value(32'(color_count[border]), 32'd158, "gr5 border count");
		check_value(32'(color_count[0]), 32'(LINE_CLKS - `VTL_H_VISIBLE),
		            "black outside visible area");
		check_value(32'(color_count[16]), 32'd0, "gr5 unknown colours");
	endtask

	task automatic gr3_pages();
		logic [3:0] border;
		do border = 4'($urandom_range(15, 1));
		while (border == 4'h3 || border == 4'h5 || border == 4'hA);
		fill_bank(4'h7, 8'hA5);
		fill_bank(4'h3, 8'h33);
		io_write(8'h44, {border, 1'b0, 3'b011});  // page 7
		wait_for_line(150);
		count_line_colors();
		check_value(32'(color_count[5]), 32'd320, "gr3 entry 5 count");
		check_value(32'(color_count[10]), 32'd320, "gr3 entry A count");
		check_value(32'(color_count[border]), 32'd158, "gr3 border count");
		io_write(8'h44, {border, 1'b1, 3'b011});  // page 3
		wait_for_line(200);
		count_line_colors();
		check_value(32'(color_count[3]), 32'd640, "gr3 page 3 entry 3 count");
		check_value(32'(color_count[border]), 32'd158, "gr3 page 3 border count");
	endtask

	task automatic skip_beat_and_blank();
		int         pulses;
		logic       prev_de;
		logic [3:0] border;
		do border = 4'($urandom_range(15, 1));
		while (border == 4'h3);
		pulses = 0;
		repeat (64) begin
			@(negedge F14M);
			if (cpu_ena)
				pulses++;
		end
		check_value(32'(pulses), 32'd16, "idle enable pulses");
		@(posedge F14M);
		#1;
		a      = 16'h4000;
		mreq_n = 1'b0;
		rd_n   = 1'b0;
		pulses = 0;
		repeat (64) begin
			@(negedge F14M);
			if (cpu_ena)
				pulses++;
		end
		check_value(32'(pulses), 32'd15, "one beat skipped on new mreq");
		@(posedge F14M);
		#1;
		mreq_n = 1'b1;
		rd_n   = 1'b1;
		io_write(8'h44, {border, 1'b1, 3'b011});  // gr3 page 3 under the blank
		@(posedge F14M);
		#1;
		blank  = 1'b1;
		// a whole visible line, pixel lags display_enable by one
		prev_de = 1'b1;
		forever begin
			@(negedge F14M);
			if (!prev_de && display_enable)
				break;
			prev_de = display_enable;
		end
		for (int i = 0; i < 797; i++) begin
			@(negedge F14M);
			check_value(32'({r, g, b}), 32'(expand(border)), "blank shows border");
		end
		@(posedge F14M);
		#1;
		blank = 1'b0;
	endtask

	initial begin
		void'($urandom(79));
		cycles  = 0;
		F14M    = 1'b0;
		RESET   = 1'b1;
		blank   = 1'b0;
		mreq_n  = 1'b1;
		iorq_n  = 1'b1;
		rd_n    = 1'b1;
		wr_n    = 1'b1;
		a       = 16'h0000;
		cpu_do  = 8'h00;
		kd      = 7'h7F;
		casin   = 1'b0;
		for (int i = 0; i < 262144; i++)
			mem[i] <= 8'(i) ^ 8'(i >> 8) ^ {6'd0, 2'(i >> 16)};  // all address bits
		repeat (5) @(posedge F14M);
		#1;
		RESET = 1'b0;

		sync_timing();
		banked_memory();
		mapped_io();
		gr5_colors();
		gr3_pages();
		skip_beat_and_blank();

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/vtl_assertions.sv
// protocol checks on the vtl_chip ports
// clock enable width, sdram write banks, display enable against hsync
`timescale 1ns/100ps
`default_nettype none

module vtl_assertions (
	input logic        F14M,
	input logic        RESET,
	input logic        cpu_ena,
	input logic        sdram_wr,
	input logic [24:0] sdram_addr,
	input logic        hsync,
	input logic        display_enable
);
	logic [3:0] wr_bank;

	assign wr_bank = sdram_addr[17:14];

	// enable is a single clock pulse
	ena_single: assert property (@(posedge F14M) disable iff (RESET)
		cpu_ena |=> !cpu_ena)
		else $error("cpu_ena high two cycles in a row");

	// only ram banks 4 to 7 are ever written
	wr_ram_only: assert property (@(posedge F14M) disable iff (RESET)
		sdram_wr |-> (wr_bank >= 4'd4 && wr_bank <= 4'd7))
		else $error("sdram write outside ram banks");

	de_in_sync: assert property (@(posedge F14M) disable iff (RESET)
		!hsync |-> !display_enable)
		else $error("display_enable high during hsync");

endmodule

bind vtl_chip vtl_assertions chk (
	.F14M(F14M), .RESET(RESET), .cpu_ena(cpu_ena),
	.sdram_wr(sdram_wr), .sdram_addr(sdram_addr),
	.hsync(hsync), .display_enable(display_enable)
);

`default_nettype wire

// File: video/video_shifter.sv
// GR5 / GR3 pixel path
// row address interleave, fetch latch, shift register and 16 colour palette
`timescale 1ns/100ps
`default_nettype none
`include "vtl_cfg.svh"

module video_shifter (
	input  logic               F14M,
	input  logic               RESET,
	input  logic               blank,
	input  vtl_pkg::raster_t   raster,
	input  vtl_pkg::vdc_regs_t regs,
	input  logic [7:0]         sdram_dout,
	output logic [13:0]        video_addr,
	output logic [5:0]         r,
	output logic [5:0]         g,
	output logic [5:0]         b
);
	logic [7:0]  y;          // line within active area
	logic [9:0]  fetch_x;    // x of the byte shown after the pipeline
	logic [13:0] row_base;
	logic [7:0]  latch_q;    // byte read at phase 1
	logic [7:0]  shift_q;    // byte being drawn
	logic [3:0]  pixel;      // palette index
	logic [11:0] rgb;

	function automatic logic [11:0] palette(input logic [3:0] idx);
		case (idx)
			4'h0:    palette = `VTL_PAL_0;
			4'h1:    palette = `VTL_PAL_1;
			4'h2:    palette = `VTL_PAL_2;
			4'h3:    palette = `VTL_PAL_3;
			4'h4:    palette = `VTL_PAL_4;
			4'h5:    palette = `VTL_PAL_5;
			4'h6:    palette = `VTL_PAL_6;
			4'h7:    palette = `VTL_PAL_7;
			4'h8:    palette = `VTL_PAL_8;
			4'h9:    palette = `VTL_PAL_9;
			4'hA:    palette = `VTL_PAL_A;
			4'hB:    palette = `VTL_PAL_B;
			4'hC:    palette = `VTL_PAL_C;
			4'hD:    palette = `VTL_PAL_D;
			4'hE:    palette = `VTL_PAL_E;
			default: palette = `VTL_PAL_F;
		endcase
	endfunction

	assign y = raster.active_y[7:0];

	// interleaved rows, 80 bytes per row group
	assign row_base = {y[2], y[1], y[0], y[5], y[4], y[3], y[7], y[6], y[7], y[6], 4'b0000};
	assign fetch_x  = raster.active_x + 10'(`VTL_FETCH_LEAD);
	assign video_addr = row_base + {7'd0, fetch_x[9:3]};

	// fetch at slot 7, data valid through slot 1, drawn from the next slot 0
	always_ff @(posedge F14M) begin
		if (raster.active_x[2:0] == 3'd1)
			latch_q <= sdram_dout;
		if (raster.active_x[2:0] == 3'd7)
			shift_q <= latch_q;
		else if (raster.active && regs.gfx_en) begin
			if (!regs.gr3)
				shift_q <= shift_q >> 1;  // lsb first
			else if (raster.active_x[1:0] == 2'd0)
				shift_q <= shift_q >> 4;  // low nibble then high
		end
	end

	always_ff @(posedge F14M) begin
		if (RESET)
			pixel <= 4'h0;
		else if (!raster.visible)
			pixel <= 4'h0;          // black in blanking
		else if (blank || raster.border)
			pixel <= regs.border;
		else if (!regs.gfx_en)
			pixel <= regs.bg;       // graphics off
		else if (regs.gr3) begin
			if (raster.active_x[1:0] == 2'd0)
				pixel <= shift_q[3:0];  // held 4 clocks
		end else begin
			pixel <= shift_q[0] ? regs.fg : regs.bg;
		end
	end

	// 4 bit components widened to 6 bits
	assign rgb = palette(pixel);
	assign r = {rgb[11:8], rgb[11:10]};
	assign g = {rgb[7:4], rgb[7:6]};
	assign b = {rgb[3:0], rgb[3:2]};

endmodule

`default_nettype wire

// File: video/video_timing.sv
// raster timing for the Laser 500 video
// h/v counters, negative syncs, area flags and memory slot strobes
`timescale 1ns/100ps
`default_nettype none
`include "vtl_cfg.svh"

module video_timing (
	input  logic             F14M,
	input  logic             RESET,
	output vtl_pkg::raster_t raster,
	output logic             hsync,
	output logic             vsync,
	output logic             display_enable
);
	localparam logic [9:0] H_VIS_START = 10'(`VTL_HSW + `VTL_HBP);          // 136
	localparam logic [9:0] H_VIS_END   = H_VIS_START + 10'(`VTL_H_VISIBLE); // 934
	localparam logic [9:0] H_LAST      = H_VIS_END + 10'(`VTL_HFP - 1);     // 943
	localparam logic [9:0] H_ACT_START = H_VIS_START + 10'(`VTL_LEFT_BORDER);
	localparam logic [9:0] H_ACT_END   = H_ACT_START + 10'(`VTL_WIDTH);
	localparam logic [9:0] V_LAST      = 10'(`VTL_V_LINES - 1);
	localparam logic [9:0] V_ACT_START = 10'(`VTL_TOP_BORDER);
	localparam logic [9:0] V_ACT_END   = V_ACT_START + 10'(`VTL_HEIGHT);

	logic [9:0] hcnt;   // pixel clock within line
	logic [9:0] vcnt;   // line within frame
	logic h_vis, v_vis, h_act, v_act;
	logic visible, active;

	always_ff @(posedge F14M) begin
		if (RESET) begin
			hcnt <= '0;
			vcnt <= '0;
		end else if (hcnt == H_LAST) begin
			hcnt <= '0;
			if (vcnt == V_LAST)
				vcnt <= '0;  // new frame
			else
				vcnt <= vcnt + 10'd1;
		end else begin
			hcnt <= hcnt + 10'd1;
		end
	end

	// sync pulses at the start of line and frame
	assign hsync = (hcnt >= 10'(`VTL_HSW));
	assign vsync = (vcnt >= 10'(`VTL_VSW));

	assign h_vis = (hcnt >= H_VIS_START) && (hcnt < H_VIS_END);
	assign v_vis = (vcnt >= 10'(`VTL_V_VIS_FIRST)) && (vcnt <= 10'(`VTL_V_VIS_LAST));
	assign h_act = (hcnt >= H_ACT_START) && (hcnt < H_ACT_END);
	assign v_act = (vcnt >= V_ACT_START) && (vcnt < V_ACT_END);

	assign visible = h_vis && v_vis;
	assign active  = visible && h_act && v_act;
	assign display_enable = visible;

	always_comb begin
		raster.slot        = hcnt[2:0];  // active start is a multiple of 8
		// free running offsets, wrap before the active area
		raster.active_x    = hcnt - H_ACT_START;
		raster.active_y    = vcnt - V_ACT_START;
		raster.visible     = visible;
		raster.border      = visible && !active;
		raster.active      = active;
		raster.video_fetch = (hcnt[2:0] == 3'd7);
		raster.refresh     = (hcnt[2:0] == 3'd3);
	end

endmodule

`default_nettype wire

// File: vtl_chip.f
+incdir+common
common/vtl_pkg.sv
video/video_timing.sv
video/video_shifter.sv
cpu/cpu_bus.sv
hw/sdram_slot_arbiter.sv
hw/vtl_chip.sv
testbench/vtl_assertions.sv
testbench/tb_vtl_chip.sv
